//--- filelist.f
logic/ibex_pkg.sv
logic/ibex_alu.sv
logic/ibex_multdiv_slow.sv
logic/ibex_ex_block.sv
dv/ibex_ex_block_sva.sv
dv/tb_ibex_ex_block.sv

//--- Makefile
TOP := tb_ibex_ex_block

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o sim
	out=$$(./obj_dir/sim); \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module ibex_ex_block

clean:
	rm -rf obj_dir

//--- dv/tb_ibex_ex_block.sv
// Execute stage testbench
`timescale 1ns/100ps

module tb_ibex_ex_block import ibex_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 100;
  // Stall cycles before the ready cycle
  localparam int MUL_STALL      = 33;
  localparam int DIV_STALL      = 34;
  localparam int ALU_REPS       = 8;
  localparam int RAND_REPS      = 6;
  localparam logic [31:0] CORNERS [5] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff,
                                          32'h8000_0000, 32'h7fff_ffff};

  logic        clk;
  logic        rst_n_i;
  alu_op_e     alu_operator;
  md_op_e      md_operator;
  logic        mult_en;
  logic        div_en;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [1:0]  md_mode;
  logic [31:0] md_a;
  logic [31:0] md_b;
  logic [31:0] adder_result;
  logic [31:0] wdata;
  logic [31:0] jump_target;
  logic        branch;
  logic        lsu_en;
  logic        lsu_ready;
  logic        ex_ready;

  // Expected response of the op in flight
  logic        exp_valid;
  string       exp_name;
  logic [31:0] exp_wdata;
  logic        exp_cmp_chk;
  logic        exp_branch;
  logic        exp_jump_chk;
  logic [31:0] exp_jump;

  int          cmp_checks;
  int          cmp_errors;
  int          seq_errors;
  integer      seed;

  ibex_ex_block #(
    .RV32M (1)
  ) i_dut (
    .clk                   (clk),
    .rst_n_i               (rst_n_i),
    .alu_operator_i        (alu_operator),
    .multdiv_operator_i    (md_operator),
    .mult_en_i             (mult_en),
    .div_en_i              (div_en),
    .alu_operand_a_i       (alu_a),
    .alu_operand_b_i       (alu_b),
    .multdiv_signed_mode_i (md_mode),
    .multdiv_operand_a_i   (md_a),
    .multdiv_operand_b_i   (md_b),
    .alu_adder_result_ex_o (adder_result),
    .regfile_wdata_ex_o    (wdata),
    .jump_target_o         (jump_target),
    .branch_decision_o     (branch),
    .lsu_en_i              (lsu_en),
    .lsu_ready_ex_i        (lsu_ready),
    .ex_ready_o            (ex_ready)
  );

  bind ibex_ex_block ibex_ex_block_sva i_sva (
    .clk             (clk),
    .rst_n_i         (rst_n_i),
    .mult_en_i       (mult_en_i),
    .div_en_i        (div_en_i),
    .lsu_en_i        (lsu_en_i),
    .ex_ready_i      (ex_ready_o),
    .jump_target_i   (jump_target_o),
    .adder_result_i  (alu_adder_result_ex_o),
    .multdiv_ready_i (multdiv_ready)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference models
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] alu_ref(alu_op_e op, logic [31:0] a, logic [31:0] b);
    logic lt_s;
    logic lt_u;
    lt_s = $signed(a) < $signed(b);
    lt_u = a < b;
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_XOR:  return a ^ b;
      ALU_OR:   return a | b;
      ALU_AND:  return a & b;
      ALU_SLL:  return a << b[4:0];
      ALU_SRL:  return a >> b[4:0];
      ALU_SRA:  return $unsigned($signed(a) >>> b[4:0]);
      ALU_EQ:   return {31'd0, a == b};
      ALU_NE:   return {31'd0, a != b};
      ALU_LT,
      ALU_SLT:  return {31'd0, lt_s};
      ALU_LTU,
      ALU_SLTU: return {31'd0, lt_u};
      ALU_GE:   return {31'd0, !lt_s};
      default:  return {31'd0, !lt_u};
    endcase
  endfunction

  // Mode bit 0 marks A signed, bit 1 marks B signed
  function automatic logic [31:0] md_ref(md_op_e op, logic [1:0] mode, logic [31:0] a,
                                         logic [31:0] b);
    logic [63:0] ax;
    logic [63:0] bx;
    logic [63:0] prod;
    logic [31:0] q;
    logic [31:0] r;
    ax   = mode[0] ? {{32{a[31]}}, a} : {32'd0, a};
    bx   = mode[1] ? {{32{b[31]}}, b} : {32'd0, b};
    prod = ax * bx;
    if (b == 32'd0) begin
      q = 32'hffff_ffff;
      r = a;
    end else if (mode == 2'b11 && a == 32'h8000_0000 && b == 32'hffff_ffff) begin
      // Signed overflow
      q = a;
      r = 32'd0;
    end else if (mode == 2'b11) begin
      q = $signed(a) / $signed(b);
      r = $signed(a) % $signed(b);
    end else begin
      q = a / b;
      r = a % b;
    end
    case (op)
      MD_OP_MULL: return prod[31:0];
      MD_OP_MULH: return prod[63:32];
      MD_OP_DIV:  return q;
      default:    return r;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Comparing process
  ////////////////////////////////////////////////////////////////////////////

  // Outputs are settled at the falling edge
  always @(negedge clk) begin
    if (rst_n_i && exp_valid && ex_ready) begin
      cmp_checks++;
      assert (wdata === exp_wdata) else begin
        cmp_errors++;
        $display("error %0t: %s result %h, expected %h", $time, exp_name, wdata, exp_wdata);
      end
      if (exp_cmp_chk) begin
        assert (branch === exp_branch) else begin
          cmp_errors++;
          $display("error %0t: %s branch %b, expected %b", $time, exp_name, branch,
                   exp_branch);
        end
      end
      if (exp_jump_chk) begin
        assert (jump_target === exp_jump) else begin
          cmp_errors++;
          $display("error %0t: jump target %h, expected %h", $time, jump_target, exp_jump);
        end
        assert (adder_result === exp_jump) else begin
          cmp_errors++;
          $display("error %0t: adder result %h, expected %h", $time, adder_result,
                   exp_jump);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_counts();
    $display("checks: %0d, value errors: %0d, sequence errors: %0d", cmp_checks, cmp_errors,
             seq_errors);
  endtask

  task automatic finish_run();
    report_counts();
    if (cmp_errors == 0 && seq_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic check_stall(string name, int got, int want);
    assert (got == want) else begin
      seq_errors++;
      $display("error %0t: %s stalled %0d cycles, expected %0d", $time, name, got, want);
    end
  endtask

  // Counts the cycles with ex_ready_o low and compares them with the expected stall
  task automatic wait_ready(string name, int want);
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!ex_ready && cnt < TIMEOUT_CYCLES) begin
      cnt++;
      @(negedge clk);
    end
    if (!ex_ready) begin
      $display("Timeout at %0t: ex_ready_o stayed low for %0d cycles", $time, TIMEOUT_CYCLES);
      seq_errors++;
      report_counts();
      $display("RESULT: FAIL");
      $finish;
    end else begin
      check_stall(name, cnt, want);
    end
  endtask

  task automatic run_alu(alu_op_e op, logic [31:0] a, logic [31:0] b);
    logic [31:0] res;
    res = alu_ref(op, a, b);
    @(posedge clk);
    alu_operator <= op;
    alu_a        <= a;
    alu_b        <= b;
    mult_en      <= 1'b0;
    div_en       <= 1'b0;
    lsu_en       <= 1'b0;
    exp_valid    <= 1'b1;
    exp_name     <= op.name();
    exp_wdata    <= res;
    exp_cmp_chk  <= (op inside {ALU_EQ, ALU_NE, ALU_LT, ALU_LTU, ALU_GE, ALU_GEU, ALU_SLT,
                                ALU_SLTU});
    exp_branch   <= res[0];
    exp_jump_chk <= (op == ALU_ADD);
    exp_jump     <= a + b;
    wait_ready(op.name(), 0);
  endtask

  // Enable stays high until the ready cycle and the next op follows at once
  task automatic run_md(md_op_e op, logic [1:0] mode, logic [31:0] a, logic [31:0] b);
    logic [31:0] res;
    logic        is_mul;
    res    = md_ref(op, mode, a, b);
    is_mul = (op == MD_OP_MULL || op == MD_OP_MULH);
    @(posedge clk);
    md_operator  <= op;
    md_mode      <= mode;
    md_a         <= a;
    md_b         <= b;
    mult_en      <= is_mul;
    div_en       <= !is_mul;
    lsu_en       <= 1'b0;
    exp_valid    <= 1'b1;
    exp_name     <= op.name();
    exp_wdata    <= res;
    exp_cmp_chk  <= 1'b0;
    exp_jump_chk <= 1'b0;
    wait_ready(op.name(), is_mul ? MUL_STALL : DIV_STALL);
  endtask

  task automatic lsu_stall(int cycles);
    @(posedge clk);
    mult_en   <= 1'b0;
    div_en    <= 1'b0;
    lsu_en    <= 1'b1;
    lsu_ready <= 1'b0;
    exp_valid <= 1'b0;
    repeat (cycles) begin
      @(negedge clk);
      assert (!ex_ready) else begin
        seq_errors++;
        $display("error %0t: ex_ready_o high while the LSU is busy", $time);
      end
    end
    @(posedge clk);
    lsu_ready <= 1'b1;
    wait_ready("LSU", 0);
    @(posedge clk);
    lsu_en    <= 1'b0;
    lsu_ready <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    alu_op_e     op;
    logic [31:0] a;
    logic [31:0] b;
    logic [1:0]  mode;
    int          m;
    int          i;
    int          j;
    seed         = 32'hd3ad6984;
    cmp_checks   = 0;
    cmp_errors   = 0;
    seq_errors   = 0;
    rst_n_i      = 1'b0;
    alu_operator = ALU_ADD;
    md_operator  = MD_OP_MULL;
    mult_en      = 1'b0;
    div_en       = 1'b0;
    alu_a        = 32'd0;
    alu_b        = 32'd0;
    md_mode      = 2'b00;
    md_a         = 32'd0;
    md_b         = 32'd0;
    lsu_en       = 1'b0;
    lsu_ready    = 1'b0;
    exp_valid    = 1'b0;
    repeat (4) @(posedge clk);
    rst_n_i <= 1'b1;
    @(negedge clk);
    assert (ex_ready) else begin
      seq_errors++;
      $display("error %0t: ex_ready_o low after reset", $time);
    end

    // All sixteen ALU ops with equal operands on the first pass
    op = op.first();
    repeat (16) begin
      for (i = 0; i < ALU_REPS; i++) begin
        a = $random(seed);
        b = (i == 0) ? a : $random(seed);
        run_alu(op, a, b);
      end
      op = op.next();
    end

    // Multiply in every signed mode
    for (m = 0; m < 4; m++) begin
      mode = 2'(m);
      for (i = 0; i < 5; i++) begin
        for (j = 0; j < 5; j++) begin
          run_md(MD_OP_MULL, mode, CORNERS[i], CORNERS[j]);
          run_md(MD_OP_MULH, mode, CORNERS[i], CORNERS[j]);
        end
      end
      for (i = 0; i < RAND_REPS; i++) begin
        a = $random(seed);
        b = $random(seed);
        run_md(MD_OP_MULL, mode, a, b);
        run_md(MD_OP_MULH, mode, a, b);
      end
    end

    // Divide unsigned then signed with corners for a zero divisor and overflow
    for (m = 0; m < 2; m++) begin
      mode = (m == 0) ? 2'b00 : 2'b11;
      for (i = 0; i < 5; i++) begin
        for (j = 0; j < 5; j++) begin
          run_md(MD_OP_DIV, mode, CORNERS[i], CORNERS[j]);
          run_md(MD_OP_REM, mode, CORNERS[i], CORNERS[j]);
        end
      end
      for (i = 0; i < RAND_REPS; i++) begin
        a = $random(seed);
        b = $random(seed);
        run_md(MD_OP_DIV, mode, a, b);
        run_md(MD_OP_REM, mode, a, b);
      end
    end

    for (i = 0; i < 4; i++) begin
      lsu_stall(1 + ($unsigned($random(seed)) % 8));
    end

    // Multiply straight into divide
    for (i = 0; i < 4; i++) begin
      run_md((i % 2 == 0) ? MD_OP_MULL : MD_OP_MULH, 2'b11, $random(seed), $random(seed));
      run_md((i % 2 == 0) ? MD_OP_DIV : MD_OP_REM, 2'b11, $random(seed), $random(seed));
    end

    @(posedge clk);
    mult_en   <= 1'b0;
    div_en    <= 1'b0;
    exp_valid <= 1'b0;
    @(posedge clk);
    finish_run();
  end

endmodule

//--- dv/ibex_ex_block_sva.sv
// Execute stage assertions
`timescale 1ns/100ps

module ibex_ex_block_sva import ibex_pkg::*; (
  input logic              clk,
  input logic              rst_n_i,
  input logic              mult_en_i,
  input logic              div_en_i,
  input logic              lsu_en_i,
  input logic              ex_ready_i,
  input logic [DATA_W-1:0] jump_target_i,
  input logic [DATA_W-1:0] adder_result_i,
  input logic              multdiv_ready_i
);

  // Nothing to wait on means no stall
  a_ready_when_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
    !(mult_en_i || div_en_i || lsu_en_i) |-> ex_ready_i)
    else $error("ex_ready_o low with no enable set");

  // Jump target is the adder output
  a_jump_is_adder: assert property (@(posedge clk) disable iff (!rst_n_i)
    jump_target_i == adder_result_i)
    else $error("jump_target_o differs from the adder result");

  // Single ready pulse per multdiv op
  a_ready_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
    multdiv_ready_i |=> !multdiv_ready_i)
    else $error("multdiv ready held high for two cycles");

endmodule

//--- logic/ibex_ex_block.sv
// Execute stage
`timescale 1ns/100ps

module ibex_ex_block import ibex_pkg::*; #(
  parameter int RV32M = 1
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  alu_op_e           alu_operator_i,
  input  md_op_e            multdiv_operator_i,
  input  logic              mult_en_i,
  input  logic              div_en_i,
  input  logic [DATA_W-1:0] alu_operand_a_i,
  input  logic [DATA_W-1:0] alu_operand_b_i,
  input  logic [1:0]        multdiv_signed_mode_i,
  input  logic [DATA_W-1:0] multdiv_operand_a_i,
  input  logic [DATA_W-1:0] multdiv_operand_b_i,
  output logic [DATA_W-1:0] alu_adder_result_ex_o,
  output logic [DATA_W-1:0] regfile_wdata_ex_o,
  output logic [DATA_W-1:0] jump_target_o,
  output logic              branch_decision_o,
  input  logic              lsu_en_i,
  input  logic              lsu_ready_ex_i,
  output logic              ex_ready_o
);

  logic [DATA_W-1:0] alu_result;
  logic [DATA_W-1:0] multdiv_result;
  logic [DATA_W:0]   md_alu_operand_a;
  logic [DATA_W:0]   md_alu_operand_b;
  logic [DATA_W+1:0] alu_adder_ext;
  logic              alu_cmp_result;
  logic              alu_is_equal;
  logic              multdiv_ready;
  logic              mult_en;
  logic              div_en;
  logic              multdiv_en;

  // Without RV32M the enables stay low and the multdiv logic is trimmed
  if (RV32M != 0) begin : gen_multdiv_on
    assign mult_en = mult_en_i;
    assign div_en  = div_en_i;
  end else begin : gen_multdiv_off
    assign mult_en = 1'b0;
    assign div_en  = 1'b0;
  end

  assign multdiv_en = mult_en | div_en;

  // Write-back data
  assign regfile_wdata_ex_o = multdiv_en ? multdiv_result : alu_result;

  // Branch and jump outputs to fetch
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_adder_result_ex_o;

  ////////////////////////////////////////////////////////////////////////////
  // ALU
  ////////////////////////////////////////////////////////////////////////////

  // The adder belongs to the multdiv for the whole op
  ibex_alu i_alu (
    .alu_operator_i      (alu_operator_i),
    .operand_a_i         (alu_operand_a_i),
    .operand_b_i         (alu_operand_b_i),
    .multdiv_operand_a_i (md_alu_operand_a),
    .multdiv_operand_b_i (md_alu_operand_b),
    .multdiv_sel_i       (multdiv_en),
    .adder_result_o      (alu_adder_result_ex_o),
    .adder_result_ext_o  (alu_adder_ext),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp_result),
    .is_equal_result_o   (alu_is_equal)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Multiplier and divider
  ////////////////////////////////////////////////////////////////////////////

  ibex_multdiv_slow i_multdiv (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .mult_en_i        (mult_en),
    .div_en_i         (div_en),
    .operator_i       (multdiv_operator_i),
    .signed_mode_i    (multdiv_signed_mode_i),
    .op_a_i           (multdiv_operand_a_i),
    .op_b_i           (multdiv_operand_b_i),
    .alu_adder_ext_i  (alu_adder_ext),
    .alu_adder_i      (alu_adder_result_ex_o),
    .equal_to_zero_i  (alu_is_equal),
    .ready_o          (multdiv_ready),
    .alu_operand_a_o  (md_alu_operand_a),
    .alu_operand_b_o  (md_alu_operand_b),
    .multdiv_result_o (multdiv_result)
  );

  // Stall priority is multdiv then LSU, single-cycle ALU ops never stall
  always_comb begin
    if (multdiv_en) begin
      ex_ready_o = multdiv_ready;
    end else if (lsu_en_i) begin
      ex_ready_o = lsu_ready_ex_i;
    end else begin
      ex_ready_o = 1'b1;
    end
  end

endmodule

//--- logic/ibex_multdiv_slow.sv
// Iterative multiplier and divider
`timescale 1ns/100ps

module ibex_multdiv_slow import ibex_pkg::*; (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              mult_en_i,
  input  logic              div_en_i,
  input  md_op_e            operator_i,
  input  logic [1:0]        signed_mode_i,
  input  logic [DATA_W-1:0] op_a_i,
  input  logic [DATA_W-1:0] op_b_i,
  input  logic [DATA_W+1:0] alu_adder_ext_i,
  input  logic [DATA_W-1:0] alu_adder_i,
  input  logic              equal_to_zero_i,
  output logic              ready_o,
  output logic [DATA_W:0]   alu_operand_a_o,
  output logic [DATA_W:0]   alu_operand_b_o,
  output logic [DATA_W-1:0] multdiv_result_o
);

  typedef enum logic [1:0] {
    MD_IDLE,
    MD_ABS_A,
    MD_ITER,
    MD_FINISH
  } md_state_e;

  md_state_e         state_q, state_d;
  logic [4:0]        cnt_q, cnt_d;
  // Product high word or remainder
  logic [DATA_W-1:0] acc_q, acc_d;
  // Multiplier bits shifting out and product low word shifting in
  // For divide the dividend shifts out and the quotient shifts in
  logic [DATA_W-1:0] op_q, op_d;
  logic              div_zero_q, div_zero_d;

  logic              md_en;
  logic              a_neg;
  logic              b_neg;
  logic              last_iter;
  logic              carry;
  logic [DATA_W-1:0] pp;
  logic              pp_ext;
  logic              acc_ext;
  logic              mult_sub;
  logic              sum_ext;
  logic [DATA_W-1:0] rem_sh;
  logic              div_ok;
  logic              is_div;
  logic              div_neg;
  logic [DATA_W-1:0] div_mag;

  assign md_en     = mult_en_i | div_en_i;
  assign a_neg     = signed_mode_i[0] & op_a_i[DATA_W-1];
  assign b_neg     = signed_mode_i[1] & op_b_i[DATA_W-1];
  assign last_iter = (cnt_q == 5'd0);
  assign carry     = alu_adder_ext_i[DATA_W+1];

  ////////////////////////////////////////////////////////////////////////////
  // Multiply step
  ////////////////////////////////////////////////////////////////////////////

  // Partial product of A with the current multiplier bit
  assign pp      = op_q[0] ? op_a_i : '0;
  assign pp_ext  = signed_mode_i[0] & pp[DATA_W-1];
  assign acc_ext = signed_mode_i[0] & acc_q[DATA_W-1];

  // Signed multiplier has a negative weight on its top bit
  assign mult_sub = last_iter & signed_mode_i[1];

  // 33rd sum bit rebuilt from the extension bits and the carry out
  assign sum_ext = acc_ext ^ pp_ext ^ mult_sub ^ carry;

  ////////////////////////////////////////////////////////////////////////////
  // Divide step
  ////////////////////////////////////////////////////////////////////////////

  // Next dividend bit enters the partial remainder
  assign rem_sh = {acc_q[DATA_W-2:0], op_q[DATA_W-1]};

  // Bit shifted out of the remainder guarantees the subtraction fits
  assign div_ok = acc_q[DATA_W-1] | carry;

  // Quotient keeps all ones on divide by zero
  assign is_div  = (operator_i == MD_OP_DIV);
  assign div_neg = is_div ? (a_neg ^ b_neg) & ~div_zero_q : a_neg;
  assign div_mag = is_div ? op_q : acc_q;

  ////////////////////////////////////////////////////////////////////////////
  // Borrowed adder operands
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    // Negated divisor by default, its zero result flags divide by zero
    alu_operand_a_o = {{DATA_W{1'b0}}, 1'b1};
    alu_operand_b_o = {~op_b_i, 1'b1};
    unique case (state_q)
      MD_ABS_A: begin
        // Magnitude of the dividend
        alu_operand_b_o = {~op_a_i, 1'b1};
      end
      MD_ITER: begin
        if (div_en_i) begin
          alu_operand_a_o = {rem_sh, 1'b1};
          // Negative divisor is added, which subtracts its magnitude
          alu_operand_b_o = b_neg ? {op_b_i, 1'b0} : {~op_b_i, 1'b1};
        end else begin
          alu_operand_a_o = {acc_q, 1'b1};
          alu_operand_b_o = mult_sub ? {~pp, 1'b1} : {pp, 1'b0};
        end
      end
      MD_FINISH: begin
        // Negated quotient or remainder for the sign fix
        alu_operand_b_o = {~div_mag, 1'b1};
      end
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    cnt_d      = cnt_q;
    acc_d      = acc_q;
    op_d       = op_q;
    div_zero_d = div_zero_q;
    unique case (state_q)
      MD_IDLE: begin
        if (md_en) begin
          acc_d      = '0;
          op_d       = op_b_i;
          cnt_d      = 5'd31;
          div_zero_d = equal_to_zero_i;
          state_d    = div_en_i ? MD_ABS_A : MD_ITER;
        end
      end
      MD_ABS_A: begin
        op_d    = a_neg ? alu_adder_i : op_a_i;
        state_d = MD_ITER;
      end
      MD_ITER: begin
        cnt_d = cnt_q - 5'd1;
        if (div_en_i) begin
          acc_d = div_ok ? alu_adder_i : rem_sh;
          op_d  = {op_q[DATA_W-2:0], div_ok};
        end else begin
          // Add then shift the 65-bit window right by one
          acc_d = {sum_ext, alu_adder_i[DATA_W-1:1]};
          op_d  = {alu_adder_i[0], op_q[DATA_W-1:1]};
        end
        if (last_iter) begin
          state_d = MD_FINISH;
        end
      end
      MD_FINISH: begin
        state_d = MD_IDLE;
      end
      default: state_d = MD_IDLE;
    endcase
    // Dropped enable abandons the op
    if (!md_en) begin
      state_d = MD_IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= MD_IDLE;
      cnt_q   <= 5'd0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  always_ff @(posedge clk) begin
    acc_q      <= acc_d;
    op_q       <= op_d;
    div_zero_q <= div_zero_d;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result
  ////////////////////////////////////////////////////////////////////////////

  assign ready_o = (state_q == MD_FINISH);

  always_comb begin
    unique case (operator_i)
      MD_OP_MULL: multdiv_result_o = op_q;
      MD_OP_MULH: multdiv_result_o = acc_q;
      default:    multdiv_result_o = div_neg ? alu_adder_i : div_mag;
    endcase
  end

endmodule

//--- logic/ibex_alu.sv
// Integer ALU
`timescale 1ns/100ps

module ibex_alu import ibex_pkg::*; (
  input  alu_op_e           alu_operator_i,
  input  logic [DATA_W-1:0] operand_a_i,
  input  logic [DATA_W-1:0] operand_b_i,
  input  logic [DATA_W:0]   multdiv_operand_a_i,
  input  logic [DATA_W:0]   multdiv_operand_b_i,
  input  logic              multdiv_sel_i,
  output logic [DATA_W-1:0] adder_result_o,
  output logic [DATA_W+1:0] adder_result_ext_o,
  output logic [DATA_W-1:0] result_o,
  output logic              comparison_result_o,
  output logic              is_equal_result_o
);

  logic              adder_negate;
  logic [DATA_W:0]   adder_in_a;
  logic [DATA_W:0]   adder_in_b;
  logic              cmp_signed;
  logic              is_less;
  logic              shift_left;
  logic              shift_arith;
  logic [4:0]        shift_amt;
  logic [DATA_W-1:0] shift_in;
  logic [DATA_W:0]   shift_ext;
  logic [DATA_W-1:0] shift_out;

  ////////////////////////////////////////////////////////////////////////////
  // Adder
  ////////////////////////////////////////////////////////////////////////////

  // Subtract for SUB and every compare
  assign adder_negate = alu_operator_i inside {ALU_SUB, ALU_EQ, ALU_NE, ALU_LT, ALU_LTU,
                                               ALU_GE, ALU_GEU, ALU_SLT, ALU_SLTU};

  // Extra LSB carries the +1 of the two's complement
  // Multdiv operands already come in that 33-bit form
  assign adder_in_a = multdiv_sel_i ? multdiv_operand_a_i : {operand_a_i, 1'b1};
  assign adder_in_b = multdiv_sel_i ? multdiv_operand_b_i :
                      {operand_b_i, 1'b0} ^ {(DATA_W+1){adder_negate}};

  // Top bit is the carry out of the data part
  assign adder_result_ext_o = {1'b0, adder_in_a} + {1'b0, adder_in_b};
  assign adder_result_o     = adder_result_ext_o[DATA_W:1];

  // Zero difference means equal operands
  assign is_equal_result_o = (adder_result_o == '0);

  ////////////////////////////////////////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////////////////////////////////////////

  assign cmp_signed = alu_operator_i inside {ALU_LT, ALU_GE, ALU_SLT};

  // Differing signs decide directly, otherwise the difference sign does
  always_comb begin
    if (operand_a_i[DATA_W-1] ^ operand_b_i[DATA_W-1]) begin
      is_less = cmp_signed ? operand_a_i[DATA_W-1] : operand_b_i[DATA_W-1];
    end else begin
      is_less = adder_result_o[DATA_W-1];
    end
  end

  always_comb begin
    unique case (alu_operator_i)
      ALU_EQ:                         comparison_result_o = is_equal_result_o;
      ALU_NE:                         comparison_result_o = ~is_equal_result_o;
      ALU_GE, ALU_GEU:                comparison_result_o = ~is_less;
      default:                        comparison_result_o = is_less;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Shifter
  ////////////////////////////////////////////////////////////////////////////

  assign shift_left  = (alu_operator_i == ALU_SLL);
  assign shift_arith = (alu_operator_i == ALU_SRA);
  assign shift_amt   = operand_b_i[4:0];

  // Left shift is a right shift on the bit-reversed word
  always_comb begin
    for (int i = 0; i < DATA_W; i++) begin
      shift_in[i] = shift_left ? operand_a_i[DATA_W-1-i] : operand_a_i[i];
    end
  end

  // Sign bit only fills in for SRA
  assign shift_ext = $unsigned($signed({shift_arith & shift_in[DATA_W-1], shift_in}) >>>
                               shift_amt);

  always_comb begin
    for (int i = 0; i < DATA_W; i++) begin
      shift_out[i] = shift_left ? shift_ext[DATA_W-1-i] : shift_ext[i];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (alu_operator_i)
      ALU_ADD, ALU_SUB:         result_o = adder_result_o;
      ALU_XOR:                  result_o = operand_a_i ^ operand_b_i;
      ALU_OR:                   result_o = operand_a_i | operand_b_i;
      ALU_AND:                  result_o = operand_a_i & operand_b_i;
      ALU_SLL, ALU_SRL, ALU_SRA: result_o = shift_out;
      // Compares and set-less-than return a single flag bit
      default:                  result_o = {{(DATA_W-1){1'b0}}, comparison_result_o};
    endcase
  end

endmodule

//--- logic/ibex_pkg.sv
// Execute stage shared definitions

package ibex_pkg;

  // Data word width
  parameter int DATA_W = 32;

  // Width of the ALU operator field
  parameter int ALU_OP_W = 4;

  ////////////////////////////////////////////////////////////////////////////
  // ALU operators
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [ALU_OP_W-1:0] {
    // Arithmetic
    ALU_ADD  = 4'h0,
    ALU_SUB  = 4'h1,
    // Bitwise logic
    ALU_XOR  = 4'h2,
    ALU_OR   = 4'h3,
    ALU_AND  = 4'h4,
    // Shifts
    ALU_SLL  = 4'h5,
    ALU_SRL  = 4'h6,
    ALU_SRA  = 4'h7,
    // Branch compares
    ALU_EQ   = 4'h8,
    ALU_NE   = 4'h9,
    ALU_LT   = 4'ha,
    ALU_LTU  = 4'hb,
    ALU_GE   = 4'hc,
    ALU_GEU  = 4'hd,
    // Set less than
    ALU_SLT  = 4'he,
    ALU_SLTU = 4'hf
  } alu_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Multiply and divide operators
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    // Low word of the product
    MD_OP_MULL = 2'b00,
    // High word of the product
    MD_OP_MULH = 2'b01,
    // Quotient
    MD_OP_DIV  = 2'b10,
    // Remainder
    MD_OP_REM  = 2'b11
  } md_op_e;

endpackage
